//--- flist.f
+incdir+common
common/calc_data_pkg.sv
common/calc_ctrl_pkg.sv
design/operand_entry.sv
arith/add_sub_unit.sv
arith/shift_add_multiplier.sv
design/calc_sequencer.sv
design/result_display.sv
design/calculator_top.sv
sim/tb_calculator.sv

//--- Bender.yml
package:
  name: calculator

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/calc_data_pkg.sv
      - common/calc_ctrl_pkg.sv
      - design/operand_entry.sv
      - arith/add_sub_unit.sv
      - arith/shift_add_multiplier.sv
      - design/calc_sequencer.sv
      - design/result_display.sv
      - design/calculator_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/tb_calculator.sv

//--- sim/tb_calculator.sv
`timescale 1ns/1ps
`include "calc_config.svh"

module tb_calculator import calc_data_pkg::*, calc_ctrl_pkg::*; ();

    localparam int WAIT_LIMIT  = 100;              // Cycles allowed from equal to complete
    localparam int ADD_LATENCY = 4;                // Equal cycle counted as the first
    localparam int MUL_LATENCY = `CALC_DATA_W + 4;
    localparam int WRAP        = 2 ** `CALC_DATA_W;
    localparam int RANDOM_RUNS = 40;

    logic       clk;
    logic       nRST;
    logic       key_valid;
    digit_t     keypad_input;
    logic [2:0] operator_input;
    logic       equal_input;
    operand_t   display_output;
    logic       complete;
    logic       overflow;

    logic       any_input;   // Key or valid operator this cycle
    operand_t   exp_result;  // Model output of the last calculation
    logic       exp_ovf;
    int         clear_stage; // 1 armed, 2 first input seen
    int         calc_count;

    calculator_top UUT (
        .clk            (clk),
        .nRST           (nRST),
        .key_valid      (key_valid),
        .keypad_input   (keypad_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .display_output (display_output),
        .complete       (complete),
        .overflow       (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 10 ns period
    end

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input int got, input int want);
        assert (got == want)
            else stop_with_error($sformatf("CHECK FAILED at %0t ns: %s is %0d, expected %0d",
                                           $time, what, got, want));
    endtask

    function automatic logic is_operator(input logic [2:0] code);
        return (code == OP_ADD) || (code == OP_SUB) || (code == OP_MUL); // One-hot only
    endfunction

    assign any_input = key_valid || is_operator(operator_input);

    // complete only drops on the cycle after a key or an operator
    complete_drop: assert property (@(posedge clk) disable iff (!nRST)
        $fell(complete) |-> $past(any_input))
        else stop_with_error($sformatf("CHECK FAILED at %0t ns: complete fell without input",
                                       $time));

    // Shown value frozen while complete holds
    display_hold: assert property (@(posedge clk) disable iff (!nRST)
        (complete && $past(complete)) |-> $stable(display_output))
        else stop_with_error($sformatf("CHECK FAILED at %0t ns: display moved while shown",
                                       $time));

    display_update: assert property (@(posedge clk) disable iff (!nRST)
        !$stable(display_output) |-> $rose(complete))
        else stop_with_error($sformatf("CHECK FAILED at %0t ns: display changed off finish",
                                       $time));

    overflow_update: assert property (@(posedge clk) disable iff (!nRST)
        !$stable(overflow) |-> $rose(complete))
        else stop_with_error($sformatf("CHECK FAILED at %0t ns: overflow changed off finish",
                                       $time));

    // One clock period driven after the edge and checked at the falling edge
    task automatic apply_cycle(input logic kv, input digit_t code, input logic [2:0] op,
                               input logic eq);
        @(posedge clk);
        #1;
        key_valid      = kv;
        keypad_input   = code;
        operator_input = op;
        equal_input    = eq;
        @(negedge clk);
        if (clear_stage == 2) begin
            check_value("complete after clearing input", int'(complete), 0);
            clear_stage = 0;
        end else if (clear_stage == 1 && (kv || is_operator(op))) begin
            check_value("complete in clearing cycle", int'(complete), 1); // Falls next cycle
            clear_stage = 2;
        end
    endtask

    task automatic idle_cycle();
        apply_cycle(1'b0, digit_t'(0), OP_NONE, 1'b0);
    endtask

    // Decimal string to operand with a wrap after each digit
    function automatic operand_t digits_value(input string s);
        int acc;
        acc = 0;
        for (int i = 0; i < s.len(); i++)
            acc = (acc * 10 + (int'(s[i]) - 48)) % WRAP;
        return operand_t'(acc);
    endfunction

    function automatic string random_digits(input int count);
        string s;
        s = "";
        for (int i = 0; i < count; i++)
            s = {s, $sformatf("%0d", $urandom % 10)};
        return s;
    endfunction

    function automatic op_t random_op();
        case ($urandom % 3)
            0:       return OP_ADD;
            1:       return OP_SUB;
            default: return OP_MUL;
        endcase
    endfunction

    // Expected result and flag from unsigned 16-bit rules
    task automatic model_result(input op_t op, input operand_t a, input operand_t b);
        product_t full;
        case (op)
            OP_ADD: begin
                full    = product_t'(a) + product_t'(b);
                exp_ovf = (full > product_t'(WRAP - 1)); // Carry out
            end
            OP_SUB: begin
                full    = product_t'(a) - product_t'(b);
                exp_ovf = (b > a); // Borrow
            end
            default: begin
                full    = product_t'(a) * product_t'(b);
                exp_ovf = (full > product_t'(WRAP - 1));
            end
        endcase
        exp_result = operand_t'(full % product_t'(WRAP));
    endtask

    // One operand's digits with optional A..F codes and gaps
    task automatic enter_digits(input string s, input bit noisy);
        for (int i = 0; i < s.len(); i++) begin
            if (noisy && ($urandom % 4 == 0))
                apply_cycle(1'b1, digit_t'(10 + $urandom % 6), OP_NONE, 1'b0); // Rejected code
            apply_cycle(1'b1, digit_t'(int'(s[i]) - 48), OP_NONE, 1'b0);
            if (noisy && ($urandom % 3 == 0))
                idle_cycle();
        end
    endtask

    task automatic run_calc(input string a_str, input op_t op, input string b_str,
                            input bit noisy);
        operand_t a_exp;
        operand_t b_exp;
        operand_t shown;
        int       cycles;
        int       latency;
        a_exp   = digits_value(a_str);
        b_exp   = digits_value(b_str);
        latency = (op == OP_MUL) ? MUL_LATENCY : ADD_LATENCY;
        if (complete)
            clear_stage = 1; // First input must drop complete
        enter_digits(a_str, noisy);
        apply_cycle(1'b0, digit_t'(0), op, 1'b0);
        enter_digits(b_str, noisy);
        apply_cycle(1'b0, digit_t'(0), OP_NONE, 1'b1); // Equal for one cycle
        cycles = 1;
        check_value("operand A", int'(UUT.operand_a), int'(a_exp));
        check_value("operand B", int'(UUT.operand_b), int'(b_exp));
        check_value("complete at equal", int'(complete), 0);
        while (!complete) begin
            if (cycles >= WAIT_LIMIT)
                stop_with_error($sformatf(
                    "Timeout at %0t ns: complete did not rise within %0d cycles",
                    $time, WAIT_LIMIT));
            if (noisy)
                apply_cycle(1'($urandom), digit_t'($urandom), 3'($urandom), 1'($urandom));
            else
                idle_cycle();
            cycles++;
        end
        check_value($sformatf("latency of %s", op.name()), cycles, latency);
        model_result(op, a_exp, b_exp);
        check_value("display_output", int'(display_output), int'(exp_result));
        check_value("overflow", int'(overflow), int'(exp_ovf));
        shown = display_output;
        repeat (1 + $urandom % 4) begin
            idle_cycle();
            check_value("complete while shown", int'(complete), 1);
            check_value("display while shown", int'(display_output), int'(shown));
        end
        calc_count++;
    endtask

    initial begin
        void'($urandom(32'hf63));
        nRST           = 1'b0;
        key_valid      = 1'b0;
        keypad_input   = '0;
        operator_input = OP_NONE;
        equal_input    = 1'b0;
        clear_stage    = 0;
        calc_count     = 0;
        repeat (5) @(posedge clk);
        #1;
        nRST = 1'b1;

        // Quiet outputs out of reset
        repeat (3) begin
            idle_cycle();
            check_value("complete after reset", int'(complete), 0);
            check_value("overflow after reset", int'(overflow), 0);
            check_value("display after reset", int'(display_output), 0);
        end

        run_calc("65535", OP_ADD, "1", 1'b0);         // Carry out and wrap to zero
        run_calc("12", OP_SUB, "305", 1'b0);          // Borrow
        run_calc("305", OP_SUB, "0", 1'b0);           // Digit zero accepted
        run_calc("255", OP_MUL, "257", 1'b0);         // Largest product without overflow
        run_calc("256", OP_MUL, "256", 1'b0);         // Just over 16 bits
        run_calc("", OP_SUB, "7", 1'b0);              // Operator as first input zeroes A
        run_calc("1234567", OP_ADD, "99999999", 1'b1); // Long entries wrap
        run_calc("0", OP_MUL, "65535", 1'b1);

        for (int n = 0; n < RANDOM_RUNS; n++)
            run_calc(random_digits(1 + $urandom % 7), random_op(),
                     random_digits(1 + $urandom % 7), 1'($urandom));

        $display("%0d calculations checked", calc_count);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- design/calculator_top.sv
`timescale 1ns/1ps

module calculator_top import calc_data_pkg::*; (
    input  logic       clk,
    input  logic       nRST,
    input  logic       key_valid,      // One-cycle key strobe
    input  digit_t     keypad_input,
    input  logic [2:0] operator_input, // One-hot add/sub/mul
    input  logic       equal_input,
    output operand_t   display_output,
    output logic       complete,
    output logic       overflow
);

    operand_t operand_a;
    operand_t operand_b;
    logic     select_second;
    logic     clear_operands;
    logic     start_add;
    logic     start_mul;
    logic     sub_sel;
    operand_t add_result;
    logic     add_ovf;
    logic     add_finish;
    operand_t mul_result;
    logic     mul_ovf;
    logic     mul_finish;

    operand_entry u_entry (
        .clk            (clk),
        .nRST           (nRST),
        .key_valid      (key_valid),
        .keypad_input   (keypad_input),
        .select_second  (select_second),
        .clear_operands (clear_operands),
        .operand_a      (operand_a),
        .operand_b      (operand_b)
    );

    calc_sequencer u_seq (
        .clk            (clk),
        .nRST           (nRST),
        .key_valid      (key_valid),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .add_finish     (add_finish),
        .mul_finish     (mul_finish),
        .select_second  (select_second),
        .clear_operands (clear_operands),
        .start_add      (start_add),
        .start_mul      (start_mul),
        .sub_sel        (sub_sel)
    );

    add_sub_unit u_add (
        .clk     (clk),
        .nRST    (nRST),
        .start   (start_add),
        .sub_sel (sub_sel),
        .in_a    (operand_a), // Operands stable through DISPATCH
        .in_b    (operand_b),
        .result  (add_result),
        .ovf     (add_ovf),
        .finish  (add_finish)
    );

    shift_add_multiplier u_mul (
        .clk    (clk),
        .nRST   (nRST),
        .start  (start_mul),
        .in_a   (operand_a),
        .in_b   (operand_b),
        .result (mul_result),
        .ovf    (mul_ovf),
        .finish (mul_finish)
    );

    result_display u_disp (
        .clk            (clk),
        .nRST           (nRST),
        .add_finish     (add_finish),
        .mul_finish     (mul_finish),
        .add_result     (add_result),
        .mul_result     (mul_result),
        .add_ovf        (add_ovf),
        .mul_ovf        (mul_ovf),
        .clear_operands (clear_operands),
        .display_output (display_output),
        .complete       (complete),
        .overflow       (overflow)
    );

endmodule

//--- design/result_display.sv
`timescale 1ns/1ps

module result_display import calc_data_pkg::*; (
    input  logic     clk,
    input  logic     nRST,
    input  logic     add_finish,
    input  logic     mul_finish,
    input  operand_t add_result,
    input  operand_t mul_result,
    input  logic     add_ovf,
    input  logic     mul_ovf,
    input  logic     clear_operands, // Next calculation started
    output operand_t display_output, // Last finished result
    output logic     complete,       // Result on display
    output logic     overflow
);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            display_output <= '0;
            overflow       <= 1'b0;
            complete       <= 1'b0;
        end else begin
            if (add_finish) begin
                display_output <= add_result;
                overflow       <= add_ovf;
                complete       <= 1'b1;
            end else if (mul_finish) begin
                display_output <= mul_result;
                overflow       <= mul_ovf;
                complete       <= 1'b1;
            end else if (clear_operands) begin
                complete <= 1'b0; // Value and flag stay until next finish
            end
        end
    end

endmodule

//--- design/calc_sequencer.sv
`timescale 1ns/1ps

module calc_sequencer import calc_ctrl_pkg::*; (
    input  logic       clk,
    input  logic       nRST,
    input  logic       key_valid,      // Any key strobe
    input  logic [2:0] operator_input, // One-hot code, sampled every cycle
    input  logic       equal_input,    // Level
    input  logic       add_finish,
    input  logic       mul_finish,
    output logic       select_second,  // Route digits to operand B
    output logic       clear_operands, // First input after a shown result
    output logic       start_add,
    output logic       start_mul,
    output logic       sub_sel         // Held with start_add
);

    seq_state_t state, next_state;
    op_t        op_q;         // Operator latched in ENTER_FIRST
    logic       showing;      // Result on display, operands stale
    logic       op_valid;     // Exactly one of the three codes
    logic       unit_done;    // Finish of the unit that was started

    assign op_valid = (operator_input == OP_ADD) || (operator_input == OP_SUB)
                   || (operator_input == OP_MUL);

    assign unit_done = (op_q == OP_MUL) ? mul_finish : add_finish;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST)
            state <= ENTER_FIRST;
        else
            state <= next_state;
    end

    always_comb begin
        next_state = state;
        case (state)
            ENTER_FIRST:
                if (op_valid)
                    next_state = ENTER_SECOND;
            ENTER_SECOND:
                if (equal_input)
                    next_state = DISPATCH;
            DISPATCH:
                next_state = WAIT_UNIT; // Start goes out this cycle
            WAIT_UNIT:
                if (unit_done)
                    next_state = SHOW;
            SHOW:
                next_state = ENTER_FIRST;
            default:
                next_state = ENTER_FIRST;
        endcase
    end

    // Operator and result-showing bookkeeping
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            op_q    <= OP_NONE;
            showing <= 1'b0;
        end else begin
            if (state == ENTER_FIRST && op_valid)
                op_q <= op_t'(operator_input);
            if (state == WAIT_UNIT && unit_done)
                showing <= 1'b1; // Display now holds a result
            else if (clear_operands)
                showing <= 1'b0;
        end
    end

    // Key or operator after a result starts a fresh calculation
    assign clear_operands = showing && (state == ENTER_FIRST) && (key_valid || op_valid);

    assign select_second = (state == ENTER_SECOND);

    assign start_add = (state == DISPATCH) && ((op_q == OP_ADD) || (op_q == OP_SUB));
    assign start_mul = (state == DISPATCH) && (op_q == OP_MUL);
    assign sub_sel   = (op_q == OP_SUB); // Stable from ENTER_FIRST on

endmodule

//--- arith/shift_add_multiplier.sv
`timescale 1ns/1ps
`include "calc_config.svh"

module shift_add_multiplier import calc_data_pkg::*; (
    input  logic     clk,
    input  logic     nRST,
    input  logic     start,  // One-cycle request
    input  operand_t in_a,   // Multiplicand
    input  operand_t in_b,   // Multiplier
    output operand_t result, // Low half of the product
    output logic     ovf,    // High half nonzero
    output logic     finish  // CALC_DATA_W+1 cycles after start
);

    localparam int STEPS = `CALC_DATA_W;       // One multiplier bit per cycle
    localparam int CNT_W = $clog2(STEPS);
    localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(STEPS - 1);

    product_t         mcand;    // Multiplicand, shifted left each step
    operand_t         mplier;   // Multiplier, LSB examined each step
    product_t         acc;      // Running partial sum
    logic [CNT_W-1:0] step_cnt; // Iteration index
    logic             busy;

    // Datapath, loaded on start and stepped while busy
    always_ff @(posedge clk) begin
        if (start) begin
            mcand  <= product_t'(in_a);
            mplier <= in_b;
            acc    <= '0;
        end else if (busy) begin
            if (mplier[0])
                acc <= acc + mcand; // Add shifted multiplicand
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // Step counter and the finish pulse
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy     <= 1'b0;
            step_cnt <= '0;
            finish   <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (start) begin
                busy     <= 1'b1;
                step_cnt <= '0;
            end else if (busy) begin
                step_cnt <= step_cnt + 1'b1;
                if (step_cnt == LAST_STEP) begin
                    busy   <= 1'b0;
                    finish <= 1'b1; // Accumulator final from here on
                end
            end
        end
    end

    assign result = acc[`CALC_DATA_W-1:0];
    assign ovf    = |acc[2*`CALC_DATA_W-1:`CALC_DATA_W]; // Product above 16 bits

endmodule

//--- arith/add_sub_unit.sv
`timescale 1ns/1ps
`include "calc_config.svh"

module add_sub_unit import calc_data_pkg::*; (
    input  logic     clk,
    input  logic     nRST,
    input  logic     start,   // One-cycle request
    input  logic     sub_sel, // 0 add, 1 subtract
    input  operand_t in_a,
    input  operand_t in_b,
    output operand_t result,  // Valid from finish on
    output logic     ovf,     // Carry out or borrow
    output logic     finish   // One cycle after start
);

    // One extra bit on top holds carry for add, borrow for sub
    logic [`CALC_DATA_W:0] sum_ext;

    always_comb begin
        if (sub_sel)
            sum_ext = {1'b0, in_a} - {1'b0, in_b}; // MSB set when in_b > in_a
        else
            sum_ext = {1'b0, in_a} + {1'b0, in_b}; // MSB is the carry
    end

    // Result and flag captured on start, held until the next start
    always_ff @(posedge clk) begin
        if (start) begin
            result <= sum_ext[`CALC_DATA_W-1:0]; // Wrapped sum or difference
            ovf    <= sum_ext[`CALC_DATA_W];
        end
    end

    // Finish simply trails start by one cycle
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST)
            finish <= 1'b0;
        else
            finish <= start;
    end

endmodule

//--- design/operand_entry.sv
`timescale 1ns/1ps
`include "calc_config.svh"

module operand_entry import calc_data_pkg::*; (
    input  logic     clk,
    input  logic     nRST,
    input  logic     key_valid,      // One-cycle key strobe
    input  digit_t   keypad_input,   // Code, valid with key_valid
    input  logic     select_second,  // High while entering operand B
    input  logic     clear_operands, // New calculation begins
    output operand_t operand_a,
    output operand_t operand_b
);

    logic     digit_ok; // Strobe with a code in 0..9
    operand_t base_a;   // Value the next digit builds on
    operand_t base_b;

    // Shift in one decimal digit, wraps at the datapath width
    function automatic operand_t shift_in_digit(input operand_t value, input digit_t digit);
        operand_t times_ten;
        times_ten = (value << 3) + (value << 1); // x8 + x2
        return times_ten + operand_t'(digit);
    endfunction

    assign digit_ok = key_valid && (keypad_input <= digit_t'(`CALC_MAX_DIGIT)); // Drop A..F codes

    // A key in the clearing cycle starts from zero
    assign base_a = clear_operands ? '0 : operand_a;
    assign base_b = clear_operands ? '0 : operand_b;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            operand_a <= '0;
            operand_b <= '0;
        end else begin
            if (clear_operands) begin
                operand_a <= '0; // Both operands restart
                operand_b <= '0;
            end
            if (digit_ok) begin
                if (select_second)
                    operand_b <= shift_in_digit(base_b, keypad_input);
                else
                    operand_a <= shift_in_digit(base_a, keypad_input); // Also first digit after clear
            end
        end
    end

endmodule

//--- common/calc_ctrl_pkg.sv
package calc_ctrl_pkg;

    // One-hot operator codes as they come off the keypad
    typedef enum logic [2:0] {
        OP_NONE = 3'b000, // Nothing latched yet
        OP_ADD  = 3'b001,
        OP_SUB  = 3'b010,
        OP_MUL  = 3'b100
    } op_t;

    // Sequencer states
    typedef enum logic [2:0] {
        ENTER_FIRST  = 3'd0, // Digits go to operand A
        ENTER_SECOND = 3'd1, // Digits go to operand B
        DISPATCH     = 3'd2, // One-cycle start to the chosen unit
        WAIT_UNIT    = 3'd3, // Hold until that unit finishes
        SHOW         = 3'd4  // Result just latched
    } seq_state_t;

endpackage

//--- common/calc_data_pkg.sv
`include "calc_config.svh"

package calc_data_pkg;

    // Operand registers, unit results and display value
    typedef logic [`CALC_DATA_W-1:0] operand_t;

    // Raw keypad code, checked against CALC_MAX_DIGIT at entry
    typedef logic [`CALC_DIGIT_W-1:0] digit_t;

    // Full-width product, high half feeds the overflow flag
    typedef logic [2*`CALC_DATA_W-1:0] product_t;

endpackage

//--- common/calc_config.svh
`ifndef CALC_CONFIG_SVH
`define CALC_CONFIG_SVH

// Datapath width shared by operands, results and display
`define CALC_DATA_W 16

// Keypad code width, one decimal digit per strobe
`define CALC_DIGIT_W 4

// Codes above this are not digits and get dropped
`define CALC_MAX_DIGIT 9

`endif
